//--- logic/pcs_block_pkg.sv
package pcs_block_pkg;

    // ##################################################
    // Tagged 64b/66b block layout.
    // ##################################################

    // Field widths.
    parameter int NB_PAYLOAD = 64;
    parameter int NB_HEADER  = 2;
    parameter int NB_CODED   = NB_HEADER + NB_PAYLOAD;
    parameter int NB_TAGGED  = NB_CODED + 1;

    // Field positions inside a tagged block.
    parameter int TAG_BIT    = NB_CODED;
    parameter int HEADER_MSB = NB_CODED - 1;
    parameter int HEADER_LSB = NB_PAYLOAD;

    // Valid sync header codes. Any other value is an error.
    parameter logic [NB_HEADER-1:0] SH_DATA = 2'b01;
    parameter logic [NB_HEADER-1:0] SH_CTRL = 2'b10;

endpackage

//--- logic/frame_pkg.sv
package frame_pkg;

    // ##################################################
    // Frame report fields.
    // ##################################################

    // Header error and tag counters cover up to 255 lanes.
    parameter int NB_COUNT = 8;

    // Parity is folded over whole payloads.
    parameter int NB_PARITY = pcs_block_pkg::NB_PAYLOAD;

endpackage

//--- logic/block_deserializer.sv
`timescale 1ns/1ns

module block_deserializer
#(
    parameter int N_LANES = 20
)
(
    input  wire                                          i_clock,
    input  wire                                          i_reset,
    input  wire                                          i_enable,
    input  wire                                          i_valid,
    input  wire [pcs_block_pkg::NB_TAGGED-1:0]           i_data,

    output wire [N_LANES*pcs_block_pkg::NB_TAGGED-1:0]   o_frame_data,
    output wire                                          o_frame_done
);

    localparam int NB_BLOCK = pcs_block_pkg::NB_TAGGED;
    localparam int NB_BUS   = N_LANES * NB_BLOCK;
    localparam int NB_INDEX = (N_LANES > 1) ? $clog2(N_LANES) : 1;
    localparam logic [NB_INDEX-1:0] LAST_LANE = NB_INDEX'(N_LANES - 1);

    logic [NB_BUS-NB_BLOCK-1:0] shift_reg;
    logic [NB_BUS-1:0]   frame_data;
    logic [NB_BUS-1:0]   shift_next;
    logic [NB_INDEX-1:0] index;
    logic                frame_done;
    logic                accept;
    logic                wrap;

    // ##################################################
    // Block shifting.
    // ##################################################

    assign accept = i_enable && i_valid;
    assign wrap   = accept && (index == LAST_LANE);

    // Newest block enters at the low end, so the first one ends up on top.
    assign shift_next = {shift_reg, i_data};

    always_ff @(posedge i_clock)
    begin
        if (accept)
        begin
            shift_reg <= shift_next[NB_BUS-NB_BLOCK-1:0];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset || wrap)
        begin
            index <= '0;
        end
        else if (accept)
        begin
            index <= index + 1'b1;
        end
    end

    // ##################################################
    // Frame output.
    // ##################################################

    always_ff @(posedge i_clock)
    begin
        if (wrap)
        begin
            frame_data <= shift_next;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= wrap;
        end
    end

    assign o_frame_data = frame_data;
    assign o_frame_done = frame_done;

endmodule

//--- logic/lane_integrity_monitor.sv
`timescale 1ns/1ns

module lane_integrity_monitor
#(
    parameter int N_LANES = 20
)
(
    input  wire                                  i_clock,
    input  wire                                  i_reset,
    input  wire                                  i_enable,
    input  wire                                  i_valid,
    input  wire [pcs_block_pkg::NB_TAGGED-1:0]   i_data,

    output wire [frame_pkg::NB_COUNT-1:0]        o_header_errors,
    output wire [frame_pkg::NB_COUNT-1:0]        o_tag_count,
    output wire [frame_pkg::NB_PARITY-1:0]       o_parity,
    output wire                                  o_report_done
);

    localparam int NB_COUNT  = frame_pkg::NB_COUNT;
    localparam int NB_PARITY = frame_pkg::NB_PARITY;
    localparam int NB_INDEX  = (N_LANES > 1) ? $clog2(N_LANES) : 1;
    localparam logic [NB_INDEX-1:0] LAST_LANE = NB_INDEX'(N_LANES - 1);

    logic [pcs_block_pkg::NB_HEADER-1:0] header;
    logic [NB_PARITY-1:0]                payload;
    logic                                header_bad;
    logic                                tag;
    logic                                accept;
    logic                                last;

    logic [NB_INDEX-1:0]  index;
    logic [NB_COUNT-1:0]  err_acc;
    logic [NB_COUNT-1:0]  tag_acc;
    logic [NB_PARITY-1:0] parity_acc;
    logic [NB_COUNT-1:0]  err_next;
    logic [NB_COUNT-1:0]  tag_next;
    logic [NB_PARITY-1:0] parity_next;

    logic [NB_COUNT-1:0]  header_errors;
    logic [NB_COUNT-1:0]  tag_count;
    logic [NB_PARITY-1:0] parity;
    logic                 report_done;

    // ##################################################
    // Block fields.
    // ##################################################

    assign header  = i_data[pcs_block_pkg::HEADER_MSB:pcs_block_pkg::HEADER_LSB];
    assign payload = i_data[pcs_block_pkg::NB_PAYLOAD-1:0];
    assign tag     = i_data[pcs_block_pkg::TAG_BIT];

    assign header_bad = (header != pcs_block_pkg::SH_DATA) &&
                        (header != pcs_block_pkg::SH_CTRL);

    assign accept = i_enable && i_valid;
    assign last   = accept && (index == LAST_LANE);

    // Running values including the current block.
    assign err_next    = err_acc + {{(NB_COUNT-1){1'b0}}, header_bad};
    assign tag_next    = tag_acc + {{(NB_COUNT-1){1'b0}}, tag};
    assign parity_next = parity_acc ^ payload;

    // ##################################################
    // Accumulation and report.
    // ##################################################

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            index         <= '0;
            err_acc       <= '0;
            tag_acc       <= '0;
            parity_acc    <= '0;
            header_errors <= '0;
            tag_count     <= '0;
            parity        <= '0;
            report_done   <= 1'b0;
        end
        else
        begin
            report_done <= last;
            if (last)
            begin
                // Publish the finished frame and start over.
                index         <= '0;
                err_acc       <= '0;
                tag_acc       <= '0;
                parity_acc    <= '0;
                header_errors <= err_next;
                tag_count     <= tag_next;
                parity        <= parity_next;
            end
            else if (accept)
            begin
                index      <= index + 1'b1;
                err_acc    <= err_next;
                tag_acc    <= tag_next;
                parity_acc <= parity_next;
            end
        end
    end

    assign o_header_errors = header_errors;
    assign o_tag_count     = tag_count;
    assign o_parity        = parity;
    assign o_report_done   = report_done;

endmodule

//--- logic/frame_assembler.sv
`timescale 1ns/1ns

module frame_assembler
#(
    parameter int N_LANES = 20
)
(
    input  wire                                          i_clock,
    input  wire                                          i_reset,
    input  wire [N_LANES*pcs_block_pkg::NB_TAGGED-1:0]   i_frame_data,
    input  wire                                          i_frame_done,
    input  wire [frame_pkg::NB_COUNT-1:0]                i_header_errors,
    input  wire [frame_pkg::NB_COUNT-1:0]                i_tag_count,
    input  wire [frame_pkg::NB_PARITY-1:0]               i_parity,
    input  wire                                          i_report_done,

    output wire                                          o_valid,
    output wire [N_LANES*pcs_block_pkg::NB_TAGGED-1:0]   o_data,
    output wire [frame_pkg::NB_COUNT-1:0]                o_header_errors,
    output wire [frame_pkg::NB_COUNT-1:0]                o_tag_count,
    output wire [frame_pkg::NB_PARITY-1:0]               o_parity
);

    localparam int NB_BUS = N_LANES * pcs_block_pkg::NB_TAGGED;

    logic                           capture;
    logic                           valid;
    logic [NB_BUS-1:0]              data;
    logic [frame_pkg::NB_COUNT-1:0] header_errors;
    logic [frame_pkg::NB_COUNT-1:0] tag_count;
    logic [frame_pkg::NB_PARITY-1:0] parity;

    // A done pulse without its partner is dropped.
    assign capture = i_frame_done && i_report_done;

    // ##################################################
    // Output frame register.
    // ##################################################

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid         <= 1'b0;
            data          <= '0;
            header_errors <= '0;
            tag_count     <= '0;
            parity        <= '0;
        end
        else
        begin
            valid <= capture;
            if (capture)
            begin
                data          <= i_frame_data;
                header_errors <= i_header_errors;
                tag_count     <= i_tag_count;
                parity        <= i_parity;
            end
        end
    end

    // Held until the next frame.
    assign o_valid         = valid;
    assign o_data          = data;
    assign o_header_errors = header_errors;
    assign o_tag_count     = tag_count;
    assign o_parity        = parity;

endmodule

//--- logic/block_frame_top.sv
`timescale 1ns/1ns

module block_frame_top
#(
    parameter int N_LANES = 20
)
(
    input  wire                                          i_clock,
    input  wire                                          i_reset,
    input  wire                                          i_enable,
    input  wire                                          i_valid,
    input  wire [pcs_block_pkg::NB_TAGGED-1:0]           i_data,

    output wire                                          o_valid,
    output wire [N_LANES*pcs_block_pkg::NB_TAGGED-1:0]   o_data,
    output wire [frame_pkg::NB_COUNT-1:0]                o_header_errors,
    output wire [frame_pkg::NB_COUNT-1:0]                o_tag_count,
    output wire [frame_pkg::NB_PARITY-1:0]               o_parity
);

    localparam int NB_BUS = N_LANES * pcs_block_pkg::NB_TAGGED;

    wire [NB_BUS-1:0]                frame_data;
    wire                             frame_done;
    wire [frame_pkg::NB_COUNT-1:0]   header_errors;
    wire [frame_pkg::NB_COUNT-1:0]   tag_count;
    wire [frame_pkg::NB_PARITY-1:0]  parity;
    wire                             report_done;

    // ##################################################
    // Grouping and monitoring run side by side.
    // ##################################################

    block_deserializer
    #(
        .N_LANES        (N_LANES)
    )
    u_block_deserializer
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_enable       (i_enable),
        .i_valid        (i_valid),
        .i_data         (i_data),
        .o_frame_data   (frame_data),
        .o_frame_done   (frame_done)
    );

    lane_integrity_monitor
    #(
        .N_LANES         (N_LANES)
    )
    u_lane_integrity_monitor
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_enable        (i_enable),
        .i_valid         (i_valid),
        .i_data          (i_data),
        .o_header_errors (header_errors),
        .o_tag_count     (tag_count),
        .o_parity        (parity),
        .o_report_done   (report_done)
    );

    frame_assembler
    #(
        .N_LANES         (N_LANES)
    )
    u_frame_assembler
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_frame_data    (frame_data),
        .i_frame_done    (frame_done),
        .i_header_errors (header_errors),
        .i_tag_count     (tag_count),
        .i_parity        (parity),
        .i_report_done   (report_done),
        .o_valid         (o_valid),
        .o_data          (o_data),
        .o_header_errors (o_header_errors),
        .o_tag_count     (o_tag_count),
        .o_parity        (o_parity)
    );

endmodule

//--- tests/frame_checker.sv
`timescale 1ns/1ns

module frame_checker
#(
    parameter int N_LANES = 4
)
(
    input  wire                                          i_clock,
    input  wire                                          i_reset,
    input  wire                                          i_enable,
    input  wire                                          i_valid,
    input  wire [pcs_block_pkg::NB_TAGGED-1:0]           i_data,
    input  wire                                          i_out_valid,
    input  wire [N_LANES*pcs_block_pkg::NB_TAGGED-1:0]   i_out_data,
    input  wire [frame_pkg::NB_COUNT-1:0]                i_header_errors,
    input  wire [frame_pkg::NB_COUNT-1:0]                i_tag_count,
    input  wire [frame_pkg::NB_PARITY-1:0]               i_parity,
    input  wire [3:0]                                    i_test_num,
    input  wire                                          i_test_end,
    output logic                                         o_busy,
    output logic [15:0]                                  o_tests_passed,
    output logic [15:0]                                  o_tests_failed
);

    localparam int NB_BLOCK  = pcs_block_pkg::NB_TAGGED;
    localparam int NB_BUS    = N_LANES * NB_BLOCK;
    localparam int NB_COUNT  = frame_pkg::NB_COUNT;
    localparam int NB_PARITY = frame_pkg::NB_PARITY;

    logic [NB_BLOCK-1:0]  group [N_LANES];
    logic [NB_BUS-1:0]    exp_data [$];
    logic [NB_COUNT-1:0]  exp_errors [$];
    logic [NB_COUNT-1:0]  exp_tags [$];
    logic [NB_PARITY-1:0] exp_parity [$];
    int                   exp_due [$];
    int                   fill = 0;
    int                   cycle = 0;
    int                   frames_seen = 0;
    int                   test_errors = 0;
    logic                 armed = 1'b0;

    // First block goes in the top slot. Headers other than 01 and 10 are errors.
    function automatic void reference_frame(input logic [NB_BLOCK-1:0] blocks [N_LANES],
        output logic [NB_BUS-1:0] bus, output logic [NB_COUNT-1:0] errors,
        output logic [NB_COUNT-1:0] tags, output logic [NB_PARITY-1:0] parity);
        logic [1:0] header;
        int         lane;
        bus    = '0;
        errors = '0;
        tags   = '0;
        parity = '0;
        for (lane = 0; lane < N_LANES; lane++)
        begin
            bus[(N_LANES-1-lane)*NB_BLOCK +: NB_BLOCK] = blocks[lane];
            header = blocks[lane][pcs_block_pkg::HEADER_MSB:pcs_block_pkg::HEADER_LSB];
            if (header == 2'b00 || header == 2'b11)
            begin
                errors = errors + NB_COUNT'(1);
            end
            tags   = tags + NB_COUNT'(blocks[lane][pcs_block_pkg::TAG_BIT]);
            parity = parity ^ blocks[lane][NB_PARITY-1:0];
        end
    endfunction

    task automatic report_problem(input string text);
        $display("%s", text);
        test_errors++;
    endtask

    task automatic compare_field(input string name, input logic [NB_BUS-1:0] expected,
        input logic [NB_BUS-1:0] actual);
        if (actual !== expected)
        begin
            report_problem($sformatf("Fail %s expected 0x%0h actual 0x%0h", name, expected,
                actual));
        end
    endtask

    task automatic check_outputs();
        if (i_out_valid)
        begin
            if (exp_due.size() == 0 || exp_due[0] != cycle)
            begin
                report_problem($sformatf("o_valid pulsed at cycle %0d with no frame due", cycle));
            end
            else
            begin
                compare_field("o_data", exp_data[0], i_out_data);
                compare_field("o_header_errors", NB_BUS'(exp_errors[0]), NB_BUS'(i_header_errors));
                compare_field("o_tag_count", NB_BUS'(exp_tags[0]), NB_BUS'(i_tag_count));
                compare_field("o_parity", NB_BUS'(exp_parity[0]), NB_BUS'(i_parity));
                void'(exp_data.pop_front());
                void'(exp_errors.pop_front());
                void'(exp_tags.pop_front());
                void'(exp_parity.pop_front());
                void'(exp_due.pop_front());
                frames_seen++;
            end
        end
        else if (exp_due.size() != 0 && exp_due[0] <= cycle)
        begin
            report_problem($sformatf("No o_valid for the frame due at cycle %0d", exp_due[0]));
            void'(exp_data.pop_front());
            void'(exp_errors.pop_front());
            void'(exp_tags.pop_front());
            void'(exp_parity.pop_front());
            void'(exp_due.pop_front());
        end
        else if (frames_seen == 0)
        begin
            // Nothing presented yet, so all outputs are still at reset.
            compare_field("o_data", '0, i_out_data);
            compare_field("o_header_errors", '0, NB_BUS'(i_header_errors));
            compare_field("o_tag_count", '0, NB_BUS'(i_tag_count));
            compare_field("o_parity", '0, NB_BUS'(i_parity));
        end
    endtask

    task automatic collect_block();
        logic [NB_BUS-1:0]    bus;
        logic [NB_COUNT-1:0]  errors;
        logic [NB_COUNT-1:0]  tags;
        logic [NB_PARITY-1:0] parity;
        group[fill] = i_data;
        fill++;
        if (fill == N_LANES)
        begin
            reference_frame(group, bus, errors, tags, parity);
            exp_data.push_back(bus);
            exp_errors.push_back(errors);
            exp_tags.push_back(tags);
            exp_parity.push_back(parity);
            // Two cycles from the last accepting edge to o_valid.
            exp_due.push_back(cycle + 2);
            fill = 0;
        end
    endtask

    always @(posedge i_clock)
    begin
        cycle = cycle + 1;
        if (armed)
        begin
            check_outputs();
        end
        if (i_reset)
        begin
            armed = 1'b1;
            fill  = 0;
            o_tests_passed <= '0;
            o_tests_failed <= '0;
        end
        else if (i_enable && i_valid)
        begin
            collect_block();
        end
        if (i_test_end)
        begin
            if (test_errors == 0)
            begin
                $display("Test %0d passed, %0d frames so far", i_test_num, frames_seen);
                o_tests_passed <= o_tests_passed + 16'd1;
            end
            else
            begin
                $display("Test %0d failed with %0d errors", i_test_num, test_errors);
                o_tests_failed <= o_tests_failed + 16'd1;
            end
            test_errors = 0;
        end
        o_busy <= (exp_due.size() != 0) || (fill != 0);
    end

endmodule

//--- tests/tb_block_frame.sv
`timescale 1ns/1ns

module tb_block_frame;

    localparam int N_LANES      = 4;
    localparam int NB_BLOCK     = pcs_block_pkg::NB_TAGGED;
    localparam int NB_BUS       = N_LANES * NB_BLOCK;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 10;
    localparam int MAX_GAP      = 3;
    localparam int N_FRAMES     = 15;
    localparam int LIMIT        = RESET_CYCLES + IDLE_CYCLES
                                  + N_FRAMES * N_LANES * (MAX_GAP + 1) + 200;
    localparam logic [31:0] SEED = 32'h40023d32;

    // Block kinds for the generator.
    localparam int KIND_CLEAN  = 0;
    localparam int KIND_HEADER = 1;
    localparam int KIND_TAGGED = 2;
    localparam int KIND_ANY    = 3;

    logic                   clock = 1'b0;
    logic                   reset;
    logic                   enable;
    logic                   valid;
    logic [NB_BLOCK-1:0]    data;
    logic [3:0]             test_num;
    logic                   test_end;
    int                     cycle_count = 0;

    wire                                out_valid;
    wire [NB_BUS-1:0]                   out_data;
    wire [frame_pkg::NB_COUNT-1:0]      header_errors;
    wire [frame_pkg::NB_COUNT-1:0]      tag_count;
    wire [frame_pkg::NB_PARITY-1:0]     parity;
    wire                                checker_busy;
    wire [15:0]                         tests_passed;
    wire [15:0]                         tests_failed;

    always #20 clock = ~clock;

    block_frame_top #(.N_LANES(N_LANES)) i_block_frame_top
    (
        .i_clock(clock), .i_reset(reset), .i_enable(enable), .i_valid(valid), .i_data(data),
        .o_valid(out_valid), .o_data(out_data), .o_header_errors(header_errors),
        .o_tag_count(tag_count), .o_parity(parity)
    );

    frame_checker #(.N_LANES(N_LANES)) u_frame_checker
    (
        .i_clock(clock), .i_reset(reset), .i_enable(enable), .i_valid(valid), .i_data(data),
        .i_out_valid(out_valid), .i_out_data(out_data), .i_header_errors(header_errors),
        .i_tag_count(tag_count), .i_parity(parity), .i_test_num(test_num),
        .i_test_end(test_end), .o_busy(checker_busy), .o_tests_passed(tests_passed),
        .o_tests_failed(tests_failed)
    );

    function automatic logic [NB_BLOCK-1:0] random_block(input int kind);
        logic        tag;
        logic [1:0]  header;
        logic [63:0] payload;
        header  = ($urandom % 2 == 0) ? 2'b01 : 2'b10;
        tag     = 1'b0;
        payload = {$urandom, $urandom};
        if (kind == KIND_HEADER || kind == KIND_ANY)
        begin
            header = 2'($urandom);
        end
        if (kind == KIND_TAGGED || kind == KIND_ANY)
        begin
            tag = 1'($urandom);
        end
        return {tag, header, payload};
    endfunction

    // A gap cycle either drops i_valid or strobes while disabled.
    task automatic idle_cycle();
        logic gap_enable;
        gap_enable = 1'($urandom);
        @(posedge clock);
        enable <= gap_enable;
        valid  <= ~gap_enable;
        data   <= {3'($urandom), $urandom, $urandom};
    endtask

    task automatic send_frames(input int count, input int kind, input int max_gap);
        int gap;
        int n;
        for (n = 0; n < count * N_LANES; n++)
        begin
            gap = int'($urandom % (max_gap + 1));
            repeat (gap) idle_cycle();
            @(posedge clock);
            enable <= 1'b1;
            valid  <= 1'b1;
            data   <= random_block(kind);
        end
    endtask

    task automatic finish_test(input logic [3:0] num);
        @(posedge clock);
        valid <= 1'b0;
        @(posedge clock);
        while (checker_busy)
        begin
            @(posedge clock);
        end
        test_num <= num;
        test_end <= 1'b1;
        @(posedge clock);
        test_end <= 1'b0;
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(SEED));
        reset    = 1'b1;
        enable   = 1'b0;
        valid    = 1'b0;
        data     = '0;
        test_num = '0;
        test_end = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        repeat (IDLE_CYCLES) idle_cycle();
        finish_test(4'd1);
        send_frames(2, KIND_CLEAN, 0);
        finish_test(4'd2);
        send_frames(2, KIND_HEADER, 0);
        finish_test(4'd3);
        send_frames(2, KIND_TAGGED, 0);
        finish_test(4'd4);
        send_frames(3, KIND_ANY, MAX_GAP);
        finish_test(4'd5);
        send_frames(6, KIND_ANY, 0);
        finish_test(4'd6);
        repeat (4) @(posedge clock);
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == 16'd6)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
logic/pcs_block_pkg.sv
logic/frame_pkg.sv
logic/block_deserializer.sv
logic/lane_integrity_monitor.sv
logic/frame_assembler.sv
logic/block_frame_top.sv
tests/frame_checker.sv
tests/tb_block_frame.sv

//--- run_sim.sh
#!/bin/sh
# Builds the block frame testbench with Verilator and runs it.

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_block_frame

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f flist.f \
    --top-module tb_block_frame --Mdir "$BUILD_DIR" -o "$SIM_BIN"
then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result.
if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
